//--- tb.f
+incdir+design
design/amb_axi_pkg.sv
design/core_axi_master.sv
design/axi_mem_slave.sv
design/amb_bus_top.sv
testbench/tb_amb_bus.sv

//--- Makefile
TOP := tb_amb_bus

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f tb.f --top-module amb_bus_top
	verilator --lint-only --timing --timescale 1ns/1ns -f tb.f --top-module $(TOP)

# pass or fail comes from the printed result, not the exit code
sim:
	verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir

//--- testbench/tb_amb_bus.sv
// table-driven testbench; expected words assume the slave's initial fill of index * 0x01010101
`timescale 1ns/1ns
`default_nettype none

`include "amb_axi_config.svh"

module tb_amb_bus;
	import amb_axi_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int LINE_WORDS  = `AMB_LINE_WORDS;
	localparam int N_ENTRIES   = 16;
	// worst case per entry is a full fill with every channel waiting
	localparam int TIMEOUT_CYCLES =
		N_ENTRIES * (`AMB_LINE_WORDS + 2) * (`AMB_MEM_WAIT + 3) + 20;

	typedef enum logic [1:0] {
		OP_CORE_RD,
		OP_CORE_WR,
		OP_CACHE_WR,
		OP_FILL
	} op_e;

	// one row of the stimulus table
	typedef struct packed {
		op_e   op;
		addr_t addr;
		word_t wdata;
		strb_t be;
		word_t exp_word;
		line_t exp_line;
		logic  back_to_back;
	} entry_t;

	logic     clk;
	logic     rstn;
	bus_req_t req;
	logic     stall;
	logic     stall_cache;
	word_t    rdata;
	logic     rdata_valid;

	entry_t stim [N_ENTRIES];

	amb_bus_top u_amb_bus_top (
		.i_clk         (clk),
		.i_rstn        (rstn),
		.i_req         (req),
		.o_stall       (stall),
		.o_stall_cache (stall_cache),
		.o_rdata       (rdata),
		.o_rdata_valid (rdata_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("error %s expected 0x%h actual 0x%h", name, exp, act);
			$display("test failed");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		if (act !== exp) begin
			$display("error %s expected 0x%h actual 0x%h", name, exp, act);
			$display("test failed");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s expected 0x%h actual 0x%h", name, exp, act);
			$display("test failed");
			$fatal(1, "run stopped");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	// beat k of the fill lands in word k of the line
	function automatic line_t line_in_beat_order(
		input word_t b0,
		input word_t b1,
		input word_t b2,
		input word_t b3
	);
		line_t l;
		l[0] = b0;
		l[1] = b1;
		l[2] = b2;
		l[3] = b3;
		return l;
	endfunction

	task automatic load_table;
		// word 5 straight from the initial contents
		stim[0]  = '{OP_CORE_RD, 32'h0000_0014, '0, 4'hf, 32'h0505_0505, '0, 1'b0};
		// full word write then read back
		stim[1]  = '{OP_CORE_WR, 32'h0000_0020, 32'hdead_beef, 4'hf, '0, '0, 1'b0};
		stim[2]  = '{OP_CORE_RD, 32'h0000_0020, '0, 4'hf, 32'hdead_beef, '0, 1'b0};
		// bytes 0 and 2 of a1b2c3d4 over 09090909
		stim[3]  = '{OP_CORE_WR, 32'h0000_0024, 32'ha1b2_c3d4, 4'b0101, '0, '0, 1'b0};
		stim[4]  = '{OP_CORE_RD, 32'h0000_0024, '0, 4'hf, 32'h09b2_09d4, '0, 1'b0};
		// miss on word 18 of line 16..19 gives wrap order 18 19 16 17
		stim[5]  = '{OP_FILL, 32'h0000_0048, '0, 4'hf, '0,
			line_in_beat_order(32'h1212_1212, 32'h1313_1313, 32'h1010_1010, 32'h1111_1111),
			1'b0};
		// write-back into word 33, then fill from word 35
		stim[6]  = '{OP_CACHE_WR, 32'h0000_0084, 32'h5a5a_0033, 4'hf, '0, '0, 1'b0};
		stim[7]  = '{OP_FILL, 32'h0000_008c, '0, 4'hf, '0,
			line_in_beat_order(32'h2323_2323, 32'h2020_2020, 32'h5a5a_0033, 32'h2222_2222),
			1'b0};
		// back to back run with no idle cycle between requests
		stim[8]  = '{OP_CORE_WR, 32'h0000_00a0, 32'h1122_3344, 4'hf, '0, '0, 1'b1};
		stim[9]  = '{OP_CORE_RD, 32'h0000_00a0, '0, 4'hf, 32'h1122_3344, '0, 1'b1};
		stim[10] = '{OP_CACHE_WR, 32'h0000_00a4, 32'hcafe_f00d, 4'hf, '0, '0, 1'b1};
		// line 40..43 from word 41 holds both new words
		stim[11] = '{OP_FILL, 32'h0000_00a4, '0, 4'hf, '0,
			line_in_beat_order(32'hcafe_f00d, 32'h2a2a_2a2a, 32'h2b2b_2b2b, 32'h1122_3344),
			1'b1};
		// low half only over 2a2a2a2a
		stim[12] = '{OP_CORE_WR, 32'h0000_00a8, 32'h0000_beef, 4'b0011, '0, '0, 1'b1};
		stim[13] = '{OP_CORE_RD, 32'h0000_00a8, '0, 4'hf, 32'h2a2a_beef, '0, 1'b1};
		stim[14] = '{OP_CORE_RD, 32'h0000_03fc, '0, 4'hf, 32'hffff_ffff, '0, 1'b1};
		// word 257 wraps onto word 1
		stim[15] = '{OP_CORE_RD, 32'h0000_0404, '0, 4'hf, 32'h0101_0101, '0, 1'b0};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// apply one entry
	////////////////////////////////////////////////////////////////////////////

	// drives the request, then samples mid-cycle until the matching stall is low
	task automatic run_entry(
		input  entry_t e,
		output word_t  got_word,
		output line_t  got_line,
		output int     beats
	);
		logic done;
		done     = 1'b0;
		beats    = 0;
		got_word = '0;
		got_line = '0;
		@(posedge clk);
		#DRIVE_DELAY;
		req              = '0;
		req.select       = (e.op == OP_CORE_RD) || (e.op == OP_CORE_WR);
		req.cache_req    = (e.op == OP_CACHE_WR) || (e.op == OP_FILL);
		req.write_enable = (e.op == OP_CORE_WR) || (e.op == OP_CACHE_WR);
		req.byte_enable  = e.be;
		req.address      = e.addr;
		req.write_data   = e.wdata;
		while (!done) begin
			@(negedge clk);
			if (rdata_valid) begin
				if (e.op == OP_FILL) begin
					// fill stall holds until the last word
					if (beats < LINE_WORDS - 1) begin
						check_flag("o_stall_cache", 1'b1, stall_cache);
					end
					if (beats < LINE_WORDS) begin
						got_line[beats] = rdata;
					end
				end else begin
					got_word = rdata;
				end
				beats++;
			end
			done = (e.op == OP_FILL) ? !stall_cache : !stall;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		word_t got_word;
		line_t got_line;
		int    beats;
		rstn = 1'b0;
		req  = '0;
		load_table();
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rstn = 1'b1;
		// idle bus after reset
		@(negedge clk);
		check_flag("o_stall", 1'b0, stall);
		check_flag("o_stall_cache", 1'b0, stall_cache);
		check_flag("o_rdata_valid", 1'b0, rdata_valid);
		for (int i = 0; i < N_ENTRIES; i++) begin
			run_entry(stim[i], got_word, got_line, beats);
			case (stim[i].op)
				OP_CORE_RD: begin
					if (beats != 1) begin
						abort_run($sformatf("core read %0d gave %0d data beats, not one",
							i, beats));
					end
					check_word("o_rdata", stim[i].exp_word, got_word);
				end
				OP_FILL: begin
					if (beats != LINE_WORDS) begin
						abort_run($sformatf("line fill %0d gave %0d data beats, not %0d",
							i, beats, LINE_WORDS));
					end
					check_line("o_rdata line", stim[i].exp_line, got_line);
				end
				default: begin
					if (beats != 0) begin
						abort_run($sformatf("write %0d returned read data", i));
					end
				end
			endcase
			// drop the request and see both stalls fall for one idle cycle
			if (!stim[i].back_to_back) begin
				@(posedge clk);
				#DRIVE_DELAY;
				req = '0;
				@(negedge clk);
				check_flag("o_stall", 1'b0, stall);
				check_flag("o_stall_cache", 1'b0, stall_cache);
			end
		end
		repeat (2) @(posedge clk);
		$display("test passed");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout, the bus did not finish the table in %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- design/amb_bus_top.sv
// bridge plus block memory; a single requester at a time, no external AXI port
`timescale 1ns/1ns
`default_nettype none

module amb_bus_top (
	input  logic                  i_clk,
	input  logic                  i_rstn,
	input  amb_axi_pkg::bus_req_t i_req,
	output logic                  o_stall,
	output logic                  o_stall_cache,
	output amb_axi_pkg::word_t    o_rdata,
	output logic                  o_rdata_valid
);
	import amb_axi_pkg::*;

	// axi channels between bridge and memory
	axi_aw_t aw;
	axi_w_t  w;
	axi_b_t  b;
	axi_ar_t ar;
	axi_r_t  r;
	logic    awready;
	logic    wready;
	logic    bready;
	logic    arready;
	logic    rready;

	core_axi_master u_core_axi_master (
		.i_clk         (i_clk),
		.i_rstn        (i_rstn),
		.i_req         (i_req),
		.o_stall       (o_stall),
		.o_stall_cache (o_stall_cache),
		.o_rdata       (o_rdata),
		.o_rdata_valid (o_rdata_valid),
		.o_aw          (aw),
		.i_awready     (awready),
		.o_w           (w),
		.i_wready      (wready),
		.i_b           (b),
		.o_bready      (bready),
		.o_ar          (ar),
		.i_arready     (arready),
		.i_r           (r),
		.o_rready      (rready)
	);

	axi_mem_slave u_axi_mem_slave (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_aw      (aw),
		.o_awready (awready),
		.i_w       (w),
		.o_wready  (wready),
		.o_b       (b),
		.i_bready  (bready),
		.i_ar      (ar),
		.o_arready (arready),
		.o_r       (r),
		.i_rready  (rready)
	);

endmodule

`default_nettype wire

//--- design/axi_mem_slave.sv
// word-addressed, size field ignored, always OKAY, one burst per direction, addresses wrap at depth
`timescale 1ns/1ns
`default_nettype none

`include "amb_axi_config.svh"

module axi_mem_slave (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	input  amb_axi_pkg::axi_aw_t i_aw,
	output logic                 o_awready,
	input  amb_axi_pkg::axi_w_t  i_w,
	output logic                 o_wready,
	output amb_axi_pkg::axi_b_t  o_b,
	input  logic                 i_bready,
	input  amb_axi_pkg::axi_ar_t i_ar,
	output logic                 o_arready,
	output amb_axi_pkg::axi_r_t  o_r,
	input  logic                 i_rready
);
	import amb_axi_pkg::*;

	localparam int IDX_W  = $clog2(`AMB_MEM_WORDS);
	localparam int WAIT_W = $clog2(`AMB_MEM_WAIT + 2);
	localparam logic [WAIT_W-1:0] WAIT_CNT = WAIT_W'(`AMB_MEM_WAIT);
	// handshake channels sharing the wait logic, aw=0 w=1 ar=2
	localparam int NCH = 3;

	word_t mem [`AMB_MEM_WORDS];

	logic [NCH-1:0]    ch_valid;
	logic [NCH-1:0]    ch_able;
	logic [NCH-1:0]    ch_ready;
	logic [WAIT_W-1:0] ch_cnt [NCH];

	// read burst
	logic             rd_busy;
	logic [IDX_W-1:0] rd_idx;
	axi_len_t         rd_len;
	axi_burst_e       rd_burst;
	axi_len_t         rd_left;
	logic             r_valid;
	logic             r_pend;
	logic [WAIT_W-1:0] r_gap;
	logic             r_sched;

	// write burst
	logic             wr_have_addr;
	logic [IDX_W-1:0] wr_idx;
	axi_len_t         wr_len;
	axi_burst_e       wr_burst;
	logic             b_valid;

	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic r_hs;
	logic b_hs;

	// next word of a burst, wrap stays inside a len+1 aligned window
	function automatic logic [IDX_W-1:0] next_index(
		input logic [IDX_W-1:0] idx,
		input axi_len_t         len,
		input axi_burst_e       burst
	);
		logic [IDX_W-1:0] mask;
		mask = IDX_W'(len);
		case (burst)
			AXI_FIXED: next_index = idx;
			AXI_WRAP:  next_index = (idx & ~mask) | ((idx + 1'b1) & mask);
			default:   next_index = idx + 1'b1;
		endcase
	endfunction

	// word i holds i * 0x01010101 at start
	initial begin
		for (int i = 0; i < `AMB_MEM_WORDS; i++) begin
			mem[i] = word_t'(i) * word_t'(32'h0101_0101);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ready wait counters
	////////////////////////////////////////////////////////////////////////////

	assign ch_valid = {i_ar.valid, i_w.valid, i_aw.valid};
	// a channel only counts while the slave can take the beat
	assign ch_able  = {!rd_busy, wr_have_addr && !b_valid, !wr_have_addr && !b_valid};

	always_comb begin
		for (int c = 0; c < NCH; c++) begin
			ch_ready[c] = ch_valid[c] && ch_able[c] && (ch_cnt[c] == WAIT_CNT);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			for (int c = 0; c < NCH; c++) begin
				ch_cnt[c] <= '0;
			end
		end else begin
			for (int c = 0; c < NCH; c++) begin
				if (ch_ready[c]) begin
					ch_cnt[c] <= '0;
				end else if (ch_valid[c] && ch_able[c]) begin
					ch_cnt[c] <= ch_cnt[c] + 1'b1;
				end
			end
		end
	end

	assign o_awready = ch_ready[0];
	assign o_wready  = ch_ready[1];
	assign o_arready = ch_ready[2];

	assign aw_hs = ch_ready[0];
	assign w_hs  = ch_ready[1];
	assign ar_hs = ch_ready[2];
	assign r_hs  = r_valid && i_rready;
	assign b_hs  = b_valid && i_bready;

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	// a new R beat is due after an AR handshake or a non-last R handshake
	assign r_sched = ar_hs || (r_hs && (rd_left != '0));

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_busy      <= 1'b0;
			rd_left      <= '0;
			r_valid      <= 1'b0;
			r_pend       <= 1'b0;
			r_gap        <= '0;
			wr_have_addr <= 1'b0;
			b_valid      <= 1'b0;
		end else begin
			if (ar_hs) begin
				rd_busy <= 1'b1;
				rd_left <= i_ar.len;
			end
			if (r_hs) begin
				r_valid <= 1'b0;
				if (rd_left == '0) begin
					rd_busy <= 1'b0;
				end else begin
					rd_left <= rd_left - 1'b1;
				end
			end
			// count the gap down, beat shows WAIT+1 cycles after the event
			if (r_pend) begin
				if (r_gap <= 1) begin
					r_valid <= 1'b1;
					r_pend  <= 1'b0;
				end else begin
					r_gap <= r_gap - 1'b1;
				end
			end
			if (r_sched) begin
				if (`AMB_MEM_WAIT == 0) begin
					r_valid <= 1'b1;
				end else begin
					r_pend <= 1'b1;
					r_gap  <= WAIT_CNT;
				end
			end
			// write side
			if (aw_hs) begin
				wr_have_addr <= 1'b1;
			end
			if (w_hs && i_w.last) begin
				wr_have_addr <= 1'b0;
				b_valid      <= 1'b1;
			end
			if (b_hs) begin
				b_valid <= 1'b0;
			end
		end
	end

	// burst addresses and attributes
	always_ff @(posedge i_clk) begin
		if (ar_hs) begin
			rd_idx   <= i_ar.addr[AXI_SIZE_WORD +: IDX_W];
			rd_len   <= i_ar.len;
			rd_burst <= i_ar.burst;
		end else if (r_hs) begin
			rd_idx <= next_index(rd_idx, rd_len, rd_burst);
		end
		if (aw_hs) begin
			wr_idx   <= i_aw.addr[AXI_SIZE_WORD +: IDX_W];
			wr_len   <= i_aw.len;
			wr_burst <= i_aw.burst;
		end else if (w_hs) begin
			wr_idx <= next_index(wr_idx, wr_len, wr_burst);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// memory array
	////////////////////////////////////////////////////////////////////////////

	// each strobe bit replaces one byte
	always @(posedge i_clk) begin
		if (w_hs) begin
			for (int b = 0; b < `AMB_DATA_W / 8; b++) begin
				if (i_w.strb[b]) begin
					mem[wr_idx][b*8 +: 8] <= i_w.data[b*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		o_r.valid = r_valid;
		o_r.data  = mem[rd_idx];
		o_r.last  = r_valid && (rd_left == '0);
		o_b.valid = b_valid;
	end

endmodule

`default_nettype wire

//--- design/core_axi_master.sv
// one read and one write in flight at most; exclusive is ignored and responses are assumed OKAY
`timescale 1ns/1ns
`default_nettype none

`include "amb_axi_config.svh"

module core_axi_master (
	input  logic                  i_clk,
	input  logic                  i_rstn,
	input  amb_axi_pkg::bus_req_t i_req,
	output logic                  o_stall,
	output logic                  o_stall_cache,
	output amb_axi_pkg::word_t    o_rdata,
	output logic                  o_rdata_valid,
	output amb_axi_pkg::axi_aw_t  o_aw,
	input  logic                  i_awready,
	output amb_axi_pkg::axi_w_t   o_w,
	input  logic                  i_wready,
	input  amb_axi_pkg::axi_b_t   i_b,
	output logic                  o_bready,
	output amb_axi_pkg::axi_ar_t  o_ar,
	input  logic                  i_arready,
	input  amb_axi_pkg::axi_r_t   i_r,
	output logic                  o_rready
);
	import amb_axi_pkg::*;

	// read side, core and cache branches kept apart
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CORE_AR,
		RD_CORE_R,
		RD_FILL_AR,
		RD_FILL_R
	} rd_state_e;

	// write side, core write and cache write-back branches
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_CORE_AW,
		WR_CORE_W,
		WR_CORE_B,
		WR_WB_AW,
		WR_WB_W,
		WR_WB_B
	} wr_state_e;

	rd_state_e rd_state;
	wr_state_e wr_state;

	logic  core_rd;
	logic  core_wr;
	logic  fill_rd;
	logic  wb_wr;
	logic  ar_hs;
	logic  r_beat;
	logic  r_last_hs;
	logic  aw_hs;
	logic  w_hs;
	logic  b_hs;
	addr_t word_addr;

	////////////////////////////////////////////////////////////////////////////
	// request decode
	////////////////////////////////////////////////////////////////////////////

	assign core_rd = i_req.select && !i_req.write_enable;
	assign core_wr = i_req.select && i_req.write_enable;
	assign fill_rd = i_req.cache_req && !i_req.write_enable;
	assign wb_wr   = i_req.cache_req && i_req.write_enable;

	// byte offset dropped, every access is a full word on the bus
	assign word_addr = {i_req.address[`AMB_ADDR_W-1:AXI_SIZE_WORD], {AXI_SIZE_WORD{1'b0}}};

	// handshakes
	assign ar_hs     = o_ar.valid && i_arready;
	assign r_beat    = i_r.valid && o_rready;
	assign r_last_hs = r_beat && i_r.last;
	assign aw_hs     = o_aw.valid && i_awready;
	assign w_hs      = o_w.valid && i_wready;
	assign b_hs      = i_b.valid && o_bready;

	////////////////////////////////////////////////////////////////////////////
	// read state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					// a line fill wins over a core read
					if (fill_rd) begin
						rd_state <= RD_FILL_AR;
					end else if (core_rd) begin
						rd_state <= RD_CORE_AR;
					end
				end
				RD_CORE_AR: begin
					if (ar_hs) begin
						rd_state <= RD_CORE_R;
					end
				end
				RD_CORE_R: begin
					if (r_last_hs) begin
						rd_state <= RD_IDLE;
					end
				end
				RD_FILL_AR: begin
					if (ar_hs) begin
						rd_state <= RD_FILL_R;
					end
				end
				RD_FILL_R: begin
					// stay for every beat of the wrap burst
					if (r_last_hs) begin
						rd_state <= RD_IDLE;
					end
				end
				default: begin
					rd_state <= RD_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// write state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					// write-back wins over a core write
					if (wb_wr) begin
						wr_state <= WR_WB_AW;
					end else if (core_wr) begin
						wr_state <= WR_CORE_AW;
					end
				end
				WR_CORE_AW: begin
					if (aw_hs) begin
						wr_state <= WR_CORE_W;
					end
				end
				WR_CORE_W: begin
					if (w_hs) begin
						wr_state <= WR_CORE_B;
					end
				end
				WR_CORE_B: begin
					if (b_hs) begin
						wr_state <= WR_IDLE;
					end
				end
				WR_WB_AW: begin
					if (aw_hs) begin
						wr_state <= WR_WB_W;
					end
				end
				WR_WB_W: begin
					if (w_hs) begin
						wr_state <= WR_WB_B;
					end
				end
				WR_WB_B: begin
					if (b_hs) begin
						wr_state <= WR_IDLE;
					end
				end
				default: begin
					wr_state <= WR_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// axi channel drive
	////////////////////////////////////////////////////////////////////////////

	// valids come straight from the state, so they hold under back-pressure
	always_comb begin
		o_ar.valid = (rd_state == RD_CORE_AR) || (rd_state == RD_FILL_AR);
		o_ar.addr  = word_addr;
		o_ar.size  = AXI_SIZE_WORD;
		// fill wraps from the missed word
		o_ar.len   = (rd_state == RD_FILL_AR) ? axi_len_t'(`AMB_LINE_WORDS - 1) : '0;
		o_ar.burst = (rd_state == RD_FILL_AR) ? AXI_WRAP : AXI_INCR;
		o_rready   = (rd_state == RD_CORE_R) || (rd_state == RD_FILL_R);
	end

	always_comb begin
		o_aw.valid = (wr_state == WR_CORE_AW) || (wr_state == WR_WB_AW);
		o_aw.addr  = word_addr;
		o_aw.size  = AXI_SIZE_WORD;
		o_aw.len   = '0;
		o_aw.burst = AXI_INCR;
		// single data beat with the requester's byte enables
		o_w.valid  = (wr_state == WR_CORE_W) || (wr_state == WR_WB_W);
		o_w.data   = i_req.write_data;
		o_w.strb   = i_req.byte_enable;
		o_w.last   = 1'b1;
		o_bready   = (wr_state == WR_CORE_B) || (wr_state == WR_WB_B);
	end

	////////////////////////////////////////////////////////////////////////////
	// requester side
	////////////////////////////////////////////////////////////////////////////

	// every accepted R beat is returned, a core read has just one
	assign o_rdata_valid = r_beat;
	assign o_rdata       = r_beat ? i_r.data : '0;

	// stall drops in the cycle of the final handshake
	assign o_stall =
		(core_rd && !((rd_state == RD_CORE_R) && r_last_hs)) ||
		(core_wr && !((wr_state == WR_CORE_B) && b_hs)) ||
		(wb_wr && !((wr_state == WR_WB_B) && b_hs));

	assign o_stall_cache = fill_rd && !((rd_state == RD_FILL_R) && r_last_hs);

endmodule

`default_nettype wire

//--- design/amb_axi_pkg.sv
// types only; widths come from the config header, bursts carry no id, cache or prot fields
`default_nettype none

`include "amb_axi_config.svh"

package amb_axi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// basic words
	////////////////////////////////////////////////////////////////////////////

	typedef logic [`AMB_DATA_W-1:0] word_t;
	typedef logic [`AMB_DATA_W/8-1:0] strb_t;
	typedef logic [`AMB_ADDR_W-1:0] addr_t;

	// one cache line, word 0 in the low bits
	typedef word_t [`AMB_LINE_WORDS-1:0] line_t;

	////////////////////////////////////////////////////////////////////////////
	// axi4 channel payloads
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] axi_len_t;
	typedef logic [2:0] axi_size_t;

	// encodings as on the AXI bus
	typedef enum logic [1:0] {
		AXI_FIXED = 2'b00,
		AXI_INCR  = 2'b01,
		AXI_WRAP  = 2'b10
	} axi_burst_e;

	// size code of a full data word (2 for 32 bit)
	localparam axi_size_t AXI_SIZE_WORD = axi_size_t'($clog2(`AMB_DATA_W / 8));

	// write address
	typedef struct packed {
		logic       valid;
		addr_t      addr;
		axi_len_t   len;
		axi_size_t  size;
		axi_burst_e burst;
	} axi_aw_t;

	// read address, same layout as aw
	typedef struct packed {
		logic       valid;
		addr_t      addr;
		axi_len_t   len;
		axi_size_t  size;
		axi_burst_e burst;
	} axi_ar_t;

	typedef struct packed {
		logic  valid;
		word_t data;
		strb_t strb;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		logic  valid;
		word_t data;
		logic  last;
	} axi_r_t;

	// response is always OKAY, so only the valid travels
	typedef struct packed {
		logic valid;
	} axi_b_t;

	////////////////////////////////////////////////////////////////////////////
	// core / cache request
	////////////////////////////////////////////////////////////////////////////

	// level-held, stable until the matching stall drops
	typedef struct packed {
		logic  select;
		logic  cache_req;
		logic  write_enable;
		strb_t byte_enable;
		logic  exclusive;
		addr_t address;
		word_t write_data;
	} bus_req_t;

endpackage

`default_nettype wire

//--- design/amb_axi_config.svh
// build-wide sizes; line words must be a power of two and memory depth a power of two
`ifndef AMB_AXI_CONFIG_SVH
`define AMB_AXI_CONFIG_SVH

// byte address width on both sides of the bridge
`define AMB_ADDR_W 32

// data word width, a whole number of bytes
`define AMB_DATA_W 32

// words per cache line
// the fill burst length is this minus one
`define AMB_LINE_WORDS 4

// slave memory depth in words
// addresses above the depth wrap around
`define AMB_MEM_WORDS 256

// cycles each slave ready stays low after its valid appears
// zero gives a zero-wait slave
`define AMB_MEM_WAIT 2

`endif
